// File: Makefile
# Verilator build and run for the DVI colour test source

SIM = obj_dir/Vtb_colour_test

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): build.f hdl/*.sv tests/*.sv
	verilator --binary --timing -j 0 --top-module tb_colour_test -f build.f

# The log decides pass or fail, tee alone would hide the result
run: compile
	./$(SIM) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
hdl/dvi_pkg.sv
hdl/display_timing.sv
hdl/colour_painter.sv
hdl/tmds_encoder.sv
hdl/tmds_link_out.sv
hdl/colour_test_top.sv
tests/tb_colour_test.sv

// File: hdl/colour_painter.sv
/*
 * Colour square painter
 * Turns position into three channel words with sync as ctrl in blanking
 */
`default_nettype none
`timescale 1ns/1ps

module colour_painter (
    input  wire logic clk_pix,
    input  wire logic rst,
    input  wire logic [dvi_pkg::cordw-1:0] sx,
    input  wire logic [dvi_pkg::cordw-1:0] sy,
    input  wire logic hsync,
    input  wire logic vsync,
    input  wire logic de,
    input  wire logic frame_start,
    output dvi_pkg::chan_word_u chan_word [dvi_pkg::tmds_channels],  // Blue, green, red
    output logic de_q,
    output logic frame_start_q
);

    import dvi_pkg::*;

    logic in_square;
    logic [3:0] paint_r, paint_g, paint_b;           // 4-bit levels
    chan_word_u word_d [tmds_channels];

    always_comb begin
        in_square = (sx < square_size) && (sy < square_size);
        if (in_square) begin
            paint_r = sx[8:5];    // Red steps every 32 columns
            paint_g = sy[8:5];    // Green steps every 32 rows
            paint_b = blue_level;
        end else begin            // Black elsewhere
            paint_r = 4'h0;
            paint_g = 4'h0;
            paint_b = 4'h0;
        end

        if (de) begin
            word_d[0].colour = {2{paint_b}};  // Nibble doubled to 8 bits
            word_d[1].colour = {2{paint_g}};
            word_d[2].colour = {2{paint_r}};
        end else begin
            for (int i = 0; i < tmds_channels; i++) begin
                word_d[i].ctrl.rsvd = '0;
                word_d[i].ctrl.code = 2'b00;
            end
            word_d[0].ctrl.code = {vsync, hsync};  // Sync only rides on blue
        end
    end

    // Channel words for the encoders
    always_ff @(posedge clk_pix) begin
        for (int i = 0; i < tmds_channels; i++) begin
            chan_word[i] <= word_d[i];
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            de_q          <= 1'b0;
            frame_start_q <= 1'b0;
        end else begin
            de_q          <= de;
            frame_start_q <= frame_start;
        end
    end

endmodule

`default_nettype wire

// File: hdl/colour_test_top.sv
/*
 * DVI colour test source, 720p
 * Timing, painter, three TMDS encoders and the link stage as parallel symbols
 */
`default_nettype none
`timescale 1ns/1ps

module colour_test_top (
    input  wire logic clk_pix,
    input  wire logic rst,
    output logic [dvi_pkg::symw-1:0] tmds_ch0,     // Blue with sync
    output logic [dvi_pkg::symw-1:0] tmds_ch1,     // Green
    output logic [dvi_pkg::symw-1:0] tmds_ch2,     // Red
    output logic [dvi_pkg::symw-1:0] tmds_clk_ch,
    output logic link_active
);

    import dvi_pkg::*;

    // Timing stage at cycle t
    logic [cordw-1:0] sx, sy;
    logic hsync, vsync, de, frame_start;

    display_timing timing_i (
        .clk_pix,
        .rst,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame_start
    );

    // Painter stage at t+1
    chan_word_u chan_word [tmds_channels];
    logic de_q, frame_start_q;

    colour_painter painter_i (
        .clk_pix,
        .rst,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame_start,
        .chan_word,
        .de_q,
        .frame_start_q
    );

    // Encoder stage at t+2
    logic [symw-1:0] sym [tmds_channels];
    logic frame_start_e;  // Frame start alongside the symbols

    for (genvar i = 0; i < tmds_channels; i++) begin : gen_enc
        tmds_encoder enc_i (
            .clk_pix,
            .rst,
            .word (chan_word[i]),
            .de   (de_q),
            .sym  (sym[i])
        );
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            frame_start_e <= 1'b0;
        end else begin
            frame_start_e <= frame_start_q;
        end
    end

    // Link stage at t+3
    tmds_link_out link_i (
        .clk_pix,
        .rst,
        .sym,
        .frame_start (frame_start_e),
        .tmds_ch0,
        .tmds_ch1,
        .tmds_ch2,
        .tmds_clk_ch,
        .link_active
    );

endmodule

`default_nettype wire

// File: hdl/display_timing.sv
/*
 * 1280x720 display timing generator
 * Screen position plus registered syncs, data enable and frame start
 */
`default_nettype none
`timescale 1ns/1ps

module display_timing (
    input  wire logic clk_pix,
    input  wire logic rst,
    output logic [dvi_pkg::cordw-1:0] sx,  // Horizontal position
    output logic [dvi_pkg::cordw-1:0] sy,  // Vertical position
    output logic hsync,
    output logic vsync,
    output logic de,                      // Active video
    output logic frame_start              // Single pulse at 0,0
);

    import dvi_pkg::*;

    logic [cordw-1:0] nx, ny;  // Position for the next cycle

    // Step along the line, wrap at line and frame end
    always_comb begin
        if (sx == h_total - 1) begin
            nx = '0;
            ny = (sy == v_total - 1) ? '0 : sy + 1'b1;
        end else begin
            nx = sx + 1'b1;
            ny = sy;
        end
    end

    // Syncs decoded from the next position so they line up with sx, sy
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx          <= '0;
            sy          <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            de          <= 1'b1;  // 0,0 is an active pixel
            frame_start <= 1'b1;
        end else begin
            sx          <= nx;
            sy          <= ny;
            hsync       <= (nx >= h_sync_start) && (nx < h_sync_end);
            vsync       <= (ny >= v_sync_start) && (ny < v_sync_end);
            de          <= (nx < h_active) && (ny < v_active);
            frame_start <= (nx == 0) && (ny == 0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/dvi_pkg.sv
/*
 * DVI colour test shared definitions
 * 720p timing, colour square geometry, TMDS tokens and the channel word
 */
`default_nettype none

package dvi_pkg;

    localparam int cordw = 12;  // Screen coordinate width

    // Horizontal timing in pixels for a 1650 pixel line
    localparam int h_active = 1280;
    localparam int h_fp     = 110;
    localparam int h_sync   = 40;
    localparam int h_bp     = 220;
    localparam int h_total  = h_active + h_fp + h_sync + h_bp;
    localparam int h_sync_start = h_active + h_fp;       // Hsync is active high
    localparam int h_sync_end   = h_sync_start + h_sync;

    // Vertical timing in lines for a 750 line frame
    localparam int v_active = 720;
    localparam int v_fp     = 5;
    localparam int v_sync   = 5;
    localparam int v_bp     = 20;
    localparam int v_total  = v_active + v_fp + v_sync + v_bp;
    localparam int v_sync_start = v_active + v_fp;       // Vsync is active high
    localparam int v_sync_end   = v_sync_start + v_sync;

    localparam int square_size = 512;          // Side of the colour square
    localparam logic [3:0] blue_level = 4'h4;  // Constant blue level in the square

    localparam int tmds_channels = 3;  // Blue, green, red
    localparam int symw = 10;          // TMDS symbol width

    // Control tokens for ctrl values {vsync, hsync} of 0 to 3
    localparam logic [symw-1:0] ctrl_tok [4] = '{
        10'b1101010100,
        10'b0010101011,
        10'b0101010100,
        10'b1010101011
    };

    localparam logic [symw-1:0] clk_lane_sym = 10'b00000_11111;  // Pixel clock on the wire

    // One channel word holds colour in active video and control in blanking
    typedef union packed {
        logic [7:0] colour;
        struct packed {
            logic [5:0] rsvd;  // Always zero
            logic [1:0] code;  // {vsync, hsync} on channel 0
        } ctrl;
    } chan_word_u;

endpackage

`default_nettype wire

// File: hdl/tmds_encoder.sv
/*
 * TMDS 8b/10b encoder for one DVI channel
 * Transition minimising, DC balancing and control tokens
 */
`default_nettype none
`timescale 1ns/1ps

module tmds_encoder (
    input  wire logic clk_pix,
    input  wire logic rst,
    input  wire dvi_pkg::chan_word_u word,   // Colour when de is high and ctrl otherwise
    input  wire logic de,
    output logic [dvi_pkg::symw-1:0] sym
);

    import dvi_pkg::*;

    logic [7:0] d;
    logic [3:0] n1_d;                  // Ones in the data byte
    logic [3:0] n1_q;                  // Ones in q_m[7:0]
    logic use_xnor;
    logic [8:0] q_m;                   // Transition minimised word
    logic signed [5:0] bal;            // Ones minus zeros of q_m[7:0]
    logic signed [5:0] disp;           // Running disparity
    logic signed [5:0] disp_next;
    logic [symw-1:0] sym_d;

    always_comb begin
        d = word.colour;
        n1_d = 4'($countones(d));
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !d[0]);

        // Stage 1 is a chain of XOR or XNOR
        q_m[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
        end
        q_m[8] = ~use_xnor;  // High for XOR

        n1_q = 4'($countones(q_m[7:0]));
        bal = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;  // 2*n1 - 8

        // Stage 2 balances DC against the running disparity
        if (disp == 0 || bal == 0) begin
            sym_d = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? disp + bal : disp - bal;
        end else if ((disp > 0 && bal > 0) || (disp < 0 && bal < 0)) begin
            sym_d = {1'b1, q_m[8], ~q_m[7:0]};        // Invert to pull back
            disp_next = disp - bal + (q_m[8] ? 6'sd2 : 6'sd0);
        end else begin
            sym_d = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp + bal - (q_m[8] ? 6'sd0 : 6'sd2);
        end

        if (!de) begin
            sym_d = ctrl_tok[word.ctrl.code];  // Blanking token
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst || !de) begin
            disp <= '0;   // Control periods restart the balance
        end else begin
            disp <= disp_next;
        end
    end

    always_ff @(posedge clk_pix) begin
        sym <= sym_d;
    end

endmodule

`default_nettype wire

// File: hdl/tmds_link_out.sv
/*
 * DVI link output stage
 * Registers the data symbols, adds the clock lane, holds blanking until frame one
 */
`default_nettype none
`timescale 1ns/1ps

module tmds_link_out (
    input  wire logic clk_pix,
    input  wire logic rst,
    input  wire logic [dvi_pkg::symw-1:0] sym [dvi_pkg::tmds_channels],
    input  wire logic frame_start,            // Aligned with sym
    output logic [dvi_pkg::symw-1:0] tmds_ch0,
    output logic [dvi_pkg::symw-1:0] tmds_ch1,
    output logic [dvi_pkg::symw-1:0] tmds_ch2,
    output logic [dvi_pkg::symw-1:0] tmds_clk_ch,
    output logic link_active
);

    import dvi_pkg::*;

    logic link_open;                  // Link is live from this symbol on
    logic [symw-1:0] gated [tmds_channels];

    always_comb begin
        link_open = link_active || frame_start;
        for (int i = 0; i < tmds_channels; i++) begin
            gated[i] = link_open ? sym[i] : ctrl_tok[0];
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            link_active <= 1'b0;
            tmds_ch0    <= ctrl_tok[0];  // Quiet blanking
            tmds_ch1    <= ctrl_tok[0];
            tmds_ch2    <= ctrl_tok[0];
            tmds_clk_ch <= clk_lane_sym;
        end else begin
            link_active <= link_open;    // Sticky until rst
            tmds_ch0    <= gated[0];
            tmds_ch1    <= gated[1];
            tmds_ch2    <= gated[2];
            tmds_clk_ch <= clk_lane_sym; // Clock lane never stops
        end
    end

endmodule

`default_nettype wire

// File: tests/colour_trace.txt
# frame x y kind value, frame counts from the first frame after link_active
# pix = red green blue levels as 3 hex digits, ctl = {vsync,hsync}, clk = lane pattern
0 0 0 pix 004
0 31 0 pix 004
0 32 0 pix 104
0 511 0 pix f04
0 512 0 pix 000
0 700 0 clk 01f
0 1279 0 pix 000
0 1280 0 ctl 0
0 1390 0 ctl 1
0 1429 0 ctl 1
0 1430 0 ctl 0
0 0 31 pix 004
0 0 32 pix 014
0 100 100 pix 334
0 300 200 pix 964
0 640 360 pix 000
0 511 511 pix ff4
0 512 511 pix 000
0 0 512 pix 000
0 1279 719 pix 000
0 0 720 ctl 0
0 100 725 ctl 2
0 1400 727 ctl 3
0 1500 729 ctl 2
0 0 730 ctl 0
1 0 0 pix 004
1 448 64 pix e24
1 1000 300 pix 000
1 256 480 pix 8f4
1 1410 500 ctl 1
1 900 726 clk 01f
1 1420 728 ctl 3
1 1649 749 ctl 0

// File: tests/tb_colour_test.sv
/*
 * Testbench for the DVI colour test source
 * Decodes the TMDS symbols and checks them against the trace file
 */
`default_nettype none
`timescale 1ns/1ps

module tb_colour_test;

    localparam int h_total = 1650;   // 720p line and frame length
    localparam int v_total = 750;
    localparam int max_points = 64;
    localparam int cycle_limit = 2 * h_total * v_total + 16 + 5000;
    // DVI control tokens for {vsync, hsync} = 0 to 3
    localparam logic [9:0] tok [4] = '{
        10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011
    };

    logic clk_pix;
    logic rst;
    logic [9:0] tmds_ch0, tmds_ch1, tmds_ch2, tmds_clk_ch;
    logic link_active;

    int tr_frame [max_points];       // Trace points in time order
    int tr_x [max_points];
    int tr_y [max_points];
    logic [23:0] tr_kind [max_points];
    logic [11:0] tr_val [max_points];
    int n_points = 0;
    int tp = 0;                      // Next trace point
    int px, py, frame;               // Position of the symbol on the outputs
    int bal [3];                     // Ones minus zeros per data lane
    int sweep_errs [4] = '{0, 0, 0, 0};
    string sweep_names [4] = '{"quiet_link", "clock_lane", "black_outside", "dc_balance"};
    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycles = 0;
    bit started = 0;
    bit done = 0;
    bit load_err = 0;

    colour_test_top dut_i (
        .clk_pix     (clk_pix),
        .rst         (rst),
        .tmds_ch0    (tmds_ch0),
        .tmds_ch1    (tmds_ch1),
        .tmds_ch2    (tmds_ch2),
        .tmds_clk_ch (tmds_clk_ch),
        .link_active (link_active)
    );

    always #5 clk_pix = ~clk_pix;    // 100 MHz stand-in for the pixel clock

    // Bit 9 set marks a control token with its code in bits 1:0, else bits 7:0 hold data
    function automatic logic [9:0] decode_symbol(input logic [9:0] s);
        logic [7:0] q;
        logic [7:0] d;
        for (int c = 0; c < 4; c++) begin
            if (s == tok[c]) return {8'h80, 2'(c)};
        end
        q = s[9] ? ~s[7:0] : s[7:0];   // Undo DC balance inversion
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);  // XOR or XNOR chain
        end
        return {2'b00, d};
    endfunction

    task automatic score_point(input string name, input logic [29:0] exp,
                               input logic [29:0] got);
        if (got == exp) begin
            pass_cnt++;
            $display("pass %s", name);
        end else begin
            fail_cnt++;
            $display("error %s: expected %h, got %h", name, exp, got);
        end
    endtask

    // Continuous checks report their first few misses only
    task automatic sweep_fail(input int k, input string msg);
        if (sweep_errs[k] < 5) $display("%s", msg);
        sweep_errs[k]++;
    endtask

    always @(negedge clk_pix) begin : check_outputs
        logic [9:0] d0, d1, d2;
        logic [29:0] exp, got;
        string name;
        if (!rst) begin
            d0 = decode_symbol(tmds_ch0);
            d1 = decode_symbol(tmds_ch1);
            d2 = decode_symbol(tmds_ch2);
            if (tmds_clk_ch != 10'b00000_11111) begin
                sweep_fail(1, $sformatf("error clock_lane: expected %h, got %h",
                                        10'b00000_11111, tmds_clk_ch));
            end
            if (!started && link_active) begin   // First live symbol is 0,0
                started = 1;
                px = 0;
                py = 0;
                frame = 0;
            end
            if (!started) begin
                if (tmds_ch0 != tok[0] || tmds_ch1 != tok[0] || tmds_ch2 != tok[0]) begin
                    sweep_fail(0, $sformatf("error quiet_link: expected %h, got %h",
                                            {tok[0], tok[0], tok[0]},
                                            {tmds_ch2, tmds_ch1, tmds_ch0}));
                end
            end else if (!link_active) begin
                sweep_fail(0, "quiet_link: link_active fell low after the link opened");
            end
            if (started && !done) begin
                if (px < 1280 && py < 720) begin            // Active video
                    if ((px >= 512 || py >= 512) && {d2, d1, d0} != 30'h0) begin
                        sweep_fail(2, $sformatf("error black_outside: expected %h, got %h at %0d,%0d",
                                                30'h0, {d2, d1, d0}, px, py));
                    end
                    if (px == 0) bal = '{0, 0, 0};           // Encoders restart each line
                    bal[0] += 2 * $countones(tmds_ch0) - 10;
                    bal[1] += 2 * $countones(tmds_ch1) - 10;
                    bal[2] += 2 * $countones(tmds_ch2) - 10;
                    if (px == 1279) begin
                        for (int c = 0; c < 3; c++) begin
                            if (bal[c] > 10 || bal[c] < -10) begin
                                sweep_fail(3, $sformatf("dc_balance: lane %0d off by %0d at line %0d",
                                                        c, bal[c], py));
                            end
                        end
                    end
                end
                if (tp < n_points && tr_frame[tp] == frame && tr_x[tp] == px
                        && tr_y[tp] == py) begin
                    name = $sformatf("f%0d_%s_%0d_%0d", frame, tr_kind[tp], px, py);
                    if (tr_kind[tp] == "pix") begin
                        exp = {2'b00, {2{tr_val[tp][11:8]}}, 2'b00, {2{tr_val[tp][7:4]}},
                               2'b00, {2{tr_val[tp][3:0]}}};
                        got = {d2, d1, d0};
                    end else if (tr_kind[tp] == "ctl") begin
                        exp = {10'h200, 10'h200, 8'h80, tr_val[tp][1:0]};  // Sync on lane 0
                        got = {d2, d1, d0};
                    end else begin
                        exp = {20'h0, tr_val[tp][9:0]};
                        got = {20'h0, tmds_clk_ch};
                    end
                    score_point(name, exp, got);
                    tp++;
                    if (tp == n_points) done = 1;
                end
                if (px == h_total - 1) begin     // Step the reference position
                    px = 0;
                    if (py == v_total - 1) begin
                        py = 0;
                        frame++;
                    end else begin
                        py++;
                    end
                end else begin
                    px++;
                end
            end
        end
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, trace not completed at point %0d of %0d",
                     cycles, tp, n_points);
            $display("sim failed");
            $finish;
        end
    end

    initial begin : main
        int fd;
        int n;
        int f, x, y;
        logic [11:0] val;
        logic [23:0] kind;
        string line;
        clk_pix = 1'b0;
        rst = 1'b1;
        fd = $fopen("tests/colour_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tests/colour_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin  // Skip the column notes
                    n = $sscanf(line, "%d %d %d %s %h", f, x, y, kind, val);
                    if (n == 5 && n_points < max_points) begin
                        tr_frame[n_points] = f;
                        tr_x[n_points] = x;
                        tr_y[n_points] = y;
                        tr_kind[n_points] = kind;
                        tr_val[n_points] = val;
                        n_points++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_points == 0) begin
            $display("no trace points were loaded");
            load_err = 1;
            done = 1;
        end
        repeat (16) @(posedge clk_pix);
        rst <= 1'b0;
        while (!done) @(posedge clk_pix);
        for (int k = 0; k < 4; k++) begin       // Continuous checks end with the run
            if (sweep_errs[k] == 0) begin
                pass_cnt++;
                $display("pass %s", sweep_names[k]);
            end else begin
                fail_cnt++;
                $display("fail %s: %0d bad samples", sweep_names[k], sweep_errs[k]);
            end
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !load_err) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
